//--- lcd_hex_display.f
+incdir+.
lcd_cmd_pkg.sv
lcd_seq_pkg.sv
hex_char_select.sv
lcd_sequencer.sv
lcd_hex_display.sv
tb_lcd_model.sv
tb_lcd_hex_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f lcd_hex_display.f \
  --top-module tb_lcd_hex_display -o sim_lcd &&
./obj_dir/sim_lcd | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tb_lcd_hex_display.sv
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module tb_lcd_hex_display;

  localparam int SHORT_BUSY = 3;
  localparam int LONG_BUSY  = 40;
  // Eight redraws of 35 writes at the slowest model setting
  localparam int TIMEOUT_CYCLES = 8 * 35 * (LONG_BUSY + 8);

  logic                   clk;
  logic                   reset;
  logic                   go;
  logic [`LCD_LINE_W-1:0] line1;
  logic [`LCD_LINE_W-1:0] line2;
  logic [`LCD_COLS-1:0]   mask1;
  logic [`LCD_COLS-1:0]   mask2;
  logic [7:0]             db_in;
  logic                   busy;
  logic                   rs;
  logic                   rw;
  logic                   e;
  logic [7:0]             db_out;
  logic                   db_oe;
  int unsigned            busy_cycles;
  logic [31:0]            lfsr_state;
  int                     cycle_cnt = 0;

  lcd_hex_display u_dut (
    .clk    (clk),
    .reset  (reset),
    .go     (go),
    .line1  (line1),
    .line2  (line2),
    .mask1  (mask1),
    .mask2  (mask2),
    .db_in  (db_in),
    .busy   (busy),
    .rs     (rs),
    .rw     (rw),
    .e      (e),
    .db_out (db_out),
    .db_oe  (db_oe)
  );

  tb_lcd_model u_lcd (
    .clk         (clk),
    .reset       (reset),
    .busy_cycles (busy_cycles),
    .rs          (rs),
    .rw          (rw),
    .e           (e),
    .db_out      (db_out),
    .db_oe       (db_oe),
    .db_in       (db_in)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, busy never returned low", cycle_cnt);
      stop_on_error();
    end
  end

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Column 0 holds the top nibble and the top mask bit
  function automatic lcd_cmd_pkg::lcd_char_t expected_char(
    input logic [`LCD_LINE_W-1:0] value,
    input logic [`LCD_COLS-1:0]   mask,
    input int                     col
  );
    logic [3:0] nib;
    nib = 4'(value >> (`LCD_LINE_W - 4 - 4 * col));
    if (!mask[`LCD_COLS - 1 - col]) begin
      return lcd_cmd_pkg::CHAR_SPACE;
    end else if (nib >= 4'd10) begin
      return lcd_cmd_pkg::CHAR_A_LOWER + 8'(nib - 4'd10);
    end else begin
      return lcd_cmd_pkg::CHAR_ZERO + 8'(nib);
    end
  endfunction

  task automatic check_cmd(input string test, input lcd_cmd_pkg::lcd_cmd_e expected);
    logic       w_rs;
    logic [7:0] w_data;
    if (u_lcd.write_count() == 0) begin
      $display("%s: instruction %h was never written to the LCD", test, expected);
      stop_on_error();
    end else begin
      u_lcd.pop_write(w_rs, w_data);
      if (w_rs !== 1'b0 || w_data !== 8'(expected)) begin
        $display("** Error %s: expected instruction %h, actual rs %b data %h",
                 test, expected, w_rs, w_data);
        stop_on_error();
      end
    end
  endtask

  task automatic check_char(input string test, input lcd_cmd_pkg::lcd_char_t expected);
    logic       w_rs;
    logic [7:0] w_data;
    if (u_lcd.write_count() == 0) begin
      $display("%s: character %h was never written to the LCD", test, expected);
      stop_on_error();
    end else begin
      u_lcd.pop_write(w_rs, w_data);
      if (w_rs !== 1'b1 || w_data !== expected) begin
        $display("** Error %s: expected character %h, actual rs %b data %h",
                 test, expected, w_rs, w_data);
        stop_on_error();
      end
    end
  endtask

  // Nothing left over and no bus violation seen by the model
  task automatic check_quiet(input string test);
    if (u_lcd.write_count() != 0) begin
      $display("%s: the LCD logged %0d writes more than expected", test,
               u_lcd.write_count());
      stop_on_error();
    end else if (u_lcd.e_while_busy) begin
      $display("%s: an e pulse came while the LCD busy flag was set", test);
      stop_on_error();
    end else if (u_lcd.e_on_read) begin
      $display("%s: an e pulse came while rw was high", test);
      stop_on_error();
    end else if (u_lcd.oe_fault) begin
      $display("%s: db_oe was high during a read or low during a write", test);
      stop_on_error();
    end
  endtask

  task automatic wait_ready();
    do @(posedge clk); while (busy);
  endtask

  task automatic start_redraw(
    input logic [`LCD_LINE_W-1:0] l1,
    input logic [`LCD_LINE_W-1:0] l2,
    input logic [`LCD_COLS-1:0]   m1,
    input logic [`LCD_COLS-1:0]   m2
  );
    @(posedge clk);
    line1 <= l1;
    line2 <= l2;
    mask1 <= m1;
    mask2 <= m2;
    go    <= 1'b1;
    @(posedge clk);
    go <= 1'b0;
  endtask

  // Home, line one, line two address, line two
  task automatic check_screen(
    input string                  test,
    input logic [`LCD_LINE_W-1:0] l1,
    input logic [`LCD_LINE_W-1:0] l2,
    input logic [`LCD_COLS-1:0]   m1,
    input logic [`LCD_COLS-1:0]   m2
  );
    check_cmd(test, lcd_cmd_pkg::CMD_HOME);
    for (int c = 0; c < `LCD_COLS; c++) begin
      check_char(test, expected_char(l1, m1, c));
    end
    check_cmd(test, lcd_cmd_pkg::CMD_LINE2);
    for (int c = 0; c < `LCD_COLS; c++) begin
      check_char(test, expected_char(l2, m2, c));
    end
    check_quiet(test);
  endtask

  task automatic redraw(
    input string                  test,
    input logic [`LCD_LINE_W-1:0] l1,
    input logic [`LCD_LINE_W-1:0] l2,
    input logic [`LCD_COLS-1:0]   m1,
    input logic [`LCD_COLS-1:0]   m2
  );
    start_redraw(l1, l2, m1, m2);
    wait_ready();
    check_screen(test, l1, l2, m1, m2);
  endtask

  task automatic test_init();
    wait_ready();
    check_cmd("init", lcd_cmd_pkg::CMD_FUNC_SET);
    check_cmd("init", lcd_cmd_pkg::CMD_DISP_ON);
    check_cmd("init", lcd_cmd_pkg::CMD_ENTRY_MODE);
    check_quiet("init");
  endtask

  task automatic test_full_mask();
    redraw("full_mask", random_bits(64), random_bits(64), '1, '1);
  endtask

  task automatic test_random_mask();
    redraw("random_mask", random_bits(64), random_bits(64),
           `LCD_COLS'(random_bits(16)), `LCD_COLS'(random_bits(16)));
  endtask

  task automatic test_hex_letters();
    redraw("hex_letters", 64'hffff_ffff_ffff_ffff, 64'h0a0a_0a0a_0a0a_0a0a, '1, '1);
  endtask

  task automatic test_long_busy();
    @(posedge clk);
    busy_cycles <= LONG_BUSY;
    redraw("long_busy", random_bits(64), random_bits(64), '1, '1);
    @(posedge clk);
    busy_cycles <= SHORT_BUSY;
  endtask

  task automatic test_go_while_busy();
    logic [`LCD_LINE_W-1:0] l1;
    logic [`LCD_LINE_W-1:0] l2;
    l1 = random_bits(64);
    l2 = random_bits(64);
    start_redraw(l1, l2, '1, '1);
    while (u_lcd.write_count() < 5) @(posedge clk);
    go <= 1'b1;
    @(posedge clk);
    go <= 1'b0;
    wait_ready();
    // A second redraw would have started by now
    repeat (50) @(posedge clk);
    if (busy) begin
      $display("go_while_busy: a go pulse during a redraw started another redraw");
      stop_on_error();
    end else begin
      check_screen("go_while_busy", l1, l2, '1, '1);
    end
  endtask

  initial begin
    lfsr_state  = 32'h0348f3b9;
    reset       = 1'b1;
    go          = 1'b0;
    line1       = '0;
    line2       = '0;
    mask1       = '0;
    mask2       = '0;
    busy_cycles = SHORT_BUSY;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_init();
    test_full_mask();
    test_random_mask();
    test_hex_letters();
    test_long_busy();
    test_go_while_busy();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- tb_lcd_model.sv
`timescale 1ns/1ps

module tb_lcd_model (
  input  logic        clk,
  input  logic        reset,
  input  int unsigned busy_cycles,
  input  logic        rs,
  input  logic        rw,
  input  logic        e,
  input  logic [7:0]  db_out,
  input  logic        db_oe,
  output logic [7:0]  db_in
);

  // Every accepted write as {rs, data}, oldest first
  logic [8:0]  writes[$];
  int unsigned busy_cnt;
  logic        e_while_busy;
  logic        e_on_read;
  logic        oe_fault;

  // Busy flag on bit 7, address counter reads as zero
  assign db_in = {busy_cnt != 0, 7'h00};

  always @(posedge clk) begin
    if (reset) begin
      busy_cnt     <= 0;
      e_while_busy <= 1'b0;
      e_on_read    <= 1'b0;
    end else if (e) begin
      writes.push_back({rs, db_out});
      // A real module would drop this write
      if (busy_cnt != 0) begin
        e_while_busy <= 1'b1;
      end
      if (rw) begin
        e_on_read <= 1'b1;
      end
      busy_cnt <= busy_cycles;
    end else if (busy_cnt != 0) begin
      busy_cnt <= busy_cnt - 1;
    end
  end

  // Controller drives the data bus only in write cycles
  always @(posedge clk) begin
    if (reset) begin
      oe_fault <= 1'b0;
    end else if ((db_oe && rw) || (e && !db_oe)) begin
      oe_fault <= 1'b1;
    end
  end

  function automatic int write_count();
    return writes.size();
  endfunction

  task automatic pop_write(output logic w_rs, output logic [7:0] w_data);
    logic [8:0] w;
    w      = writes.pop_front();
    w_rs   = w[8];
    w_data = w[7:0];
  endtask

endmodule

//--- lcd_hex_display.sv
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_hex_display (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  logic [`LCD_LINE_W-1:0] line1,
  input  logic [`LCD_LINE_W-1:0] line2,
  input  logic [`LCD_COLS-1:0]   mask1,
  input  logic [`LCD_COLS-1:0]   mask2,
  input  logic [7:0]             db_in,
  output logic                   busy,
  output logic                   rs,
  output logic                   rw,
  output logic                   e,
  output logic [7:0]             db_out,
  output logic                   db_oe
);

  logic [3:0]             col;
  logic                   line;
  lcd_cmd_pkg::lcd_char_t char_code;

  lcd_sequencer u_seq (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .char_code (char_code),
    .db_in     (db_in),
    .col       (col),
    .line      (line),
    .busy      (busy),
    .rs        (rs),
    .rw        (rw),
    .e         (e),
    .db_oe     (db_oe),
    .db_out    (db_out)
  );

  // Character for the column the sequencer is about to write
  hex_char_select u_sel (
    .col       (col),
    .line      (line),
    .line1     (line1),
    .line2     (line2),
    .mask1     (mask1),
    .mask2     (mask2),
    .char_code (char_code)
  );

  // Busy is only released while the FSM waits for go
  a_free_means_idle: assert property (@(posedge clk) disable iff (reset)
    !busy |-> (u_seq.state == lcd_seq_pkg::S_IDLE));

endmodule

//--- lcd_sequencer.sv
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    go,
  input  lcd_cmd_pkg::lcd_char_t  char_code,
  input  logic [7:0]              db_in,
  output logic [3:0]              col,
  output logic                    line,
  output logic                    busy,
  output logic                    rs,
  output logic                    rw,
  output logic                    e,
  output logic                    db_oe,
  output logic [7:0]              db_out
);

  lcd_seq_pkg::seq_state_e state;
  lcd_seq_pkg::seq_step_e  step;
  lcd_cmd_pkg::lcd_cmd_e   step_cmd;

  logic                           is_data_step;
  logic                           col_last;
  logic                           lcd_ready;
  logic [$clog2(`LCD_POLL_MAX):0] poll_cnt;

  // Busy flag is bit 7 of the instruction register
  assign lcd_ready = !db_in[7];

  assign is_data_step = (step == lcd_seq_pkg::LINE1) || (step == lcd_seq_pkg::LINE2);
  assign col_last     = (col == 4'(`LCD_COLS - 1));

  // Instruction for each non-data step
  always_comb begin
    case (step)
      lcd_seq_pkg::INIT_FUNC:  step_cmd = lcd_cmd_pkg::CMD_FUNC_SET;
      lcd_seq_pkg::INIT_DISP:  step_cmd = lcd_cmd_pkg::CMD_DISP_ON;
      lcd_seq_pkg::INIT_ENTRY: step_cmd = lcd_cmd_pkg::CMD_ENTRY_MODE;
      lcd_seq_pkg::LINE2_ADDR: step_cmd = lcd_cmd_pkg::CMD_LINE2;
      default:                 step_cmd = lcd_cmd_pkg::CMD_HOME;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= lcd_seq_pkg::S_POLL;
      step  <= lcd_seq_pkg::INIT_FUNC;
      col   <= '0;
      line  <= 1'b0;
      busy  <= 1'b1;
      rs    <= 1'b0;
      rw    <= 1'b1;
      e     <= 1'b0;
      db_oe <= 1'b0;
    end else begin
      case (state)
        lcd_seq_pkg::S_POLL: begin
          // Start the write in the cycle after the flag reads clear
          if (lcd_ready) begin
            rw    <= 1'b0;
            db_oe <= 1'b1;
            e     <= 1'b1;
            if (is_data_step) begin
              rs    <= 1'b1;
              state <= lcd_seq_pkg::S_DATA;
            end else begin
              rs    <= 1'b0;
              state <= lcd_seq_pkg::S_INSTR;
            end
          end
        end

        lcd_seq_pkg::S_INSTR, lcd_seq_pkg::S_DATA: begin
          e     <= 1'b0;
          state <= lcd_seq_pkg::S_RELEASE;
        end

        lcd_seq_pkg::S_RELEASE: begin
          // Back to instruction register read for the next poll
          rs    <= 1'b0;
          rw    <= 1'b1;
          db_oe <= 1'b0;
          state <= lcd_seq_pkg::S_NEXT;
        end

        lcd_seq_pkg::S_NEXT: begin
          state <= lcd_seq_pkg::S_POLL;
          case (step)
            lcd_seq_pkg::INIT_FUNC:  step <= lcd_seq_pkg::INIT_DISP;
            lcd_seq_pkg::INIT_DISP:  step <= lcd_seq_pkg::INIT_ENTRY;
            lcd_seq_pkg::INIT_ENTRY: begin
              busy  <= 1'b0;
              state <= lcd_seq_pkg::S_IDLE;
            end
            lcd_seq_pkg::HOME:       step <= lcd_seq_pkg::LINE1;
            lcd_seq_pkg::LINE1: begin
              col <= col + 4'd1;
              // Column wraps to 0, continue on line two
              if (col_last) begin
                line <= 1'b1;
                step <= lcd_seq_pkg::LINE2_ADDR;
              end
            end
            lcd_seq_pkg::LINE2_ADDR: step <= lcd_seq_pkg::LINE2;
            default: begin
              col <= col + 4'd1;
              if (col_last) begin
                line  <= 1'b0;
                busy  <= 1'b0;
                state <= lcd_seq_pkg::S_IDLE;
              end
            end
          endcase
        end

        lcd_seq_pkg::S_IDLE: begin
          if (go) begin
            busy  <= 1'b1;
            step  <= lcd_seq_pkg::HOME;
            state <= lcd_seq_pkg::S_POLL;
          end
        end

        default: state <= lcd_seq_pkg::S_POLL;
      endcase
    end
  end

  // Write data, loaded as the write cycle starts
  always_ff @(posedge clk) begin
    if (state == lcd_seq_pkg::S_POLL && lcd_ready) begin
      db_out <= is_data_step ? char_code : 8'(step_cmd);
    end
  end

  // Length of the current busy wait
  always_ff @(posedge clk) begin
    if (reset) begin
      poll_cnt <= '0;
    end else if (state == lcd_seq_pkg::S_POLL) begin
      poll_cnt <= poll_cnt + 1'b1;
    end else begin
      poll_cnt <= '0;
    end
  end

  a_e_in_write: assert property (@(posedge clk) disable iff (reset)
    e |-> (state == lcd_seq_pkg::S_INSTR || state == lcd_seq_pkg::S_DATA));

  a_oe_needs_write: assert property (@(posedge clk) disable iff (reset)
    db_oe |-> !rw);

  a_poll_bounded: assert property (@(posedge clk) disable iff (reset)
    poll_cnt < `LCD_POLL_MAX);

endmodule

//--- hex_char_select.sv
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module hex_char_select (
  input  logic [3:0]               col,
  input  logic                     line,
  input  logic [`LCD_LINE_W-1:0]   line1,
  input  logic [`LCD_LINE_W-1:0]   line2,
  input  logic [`LCD_COLS-1:0]     mask1,
  input  logic [`LCD_COLS-1:0]     mask2,
  output lcd_cmd_pkg::lcd_char_t   char_code
);

  logic [`LCD_LINE_W-1:0] sel_value;
  logic [`LCD_COLS-1:0]   sel_mask;
  logic [3:0]             pos;
  logic [3:0]             digit;
  logic                   show;

  // Hex digit to its ASCII code, lowercase letters
  function automatic lcd_cmd_pkg::lcd_char_t to_hex_char(input logic [3:0] d);
    if (d < 4'd10) begin
      return lcd_cmd_pkg::CHAR_ZERO + 8'(d);
    end else begin
      return lcd_cmd_pkg::CHAR_A_LOWER + 8'(d) - 8'd10;
    end
  endfunction

  assign sel_value = line ? line2 : line1;
  assign sel_mask  = line ? mask2 : mask1;

  // Column 0 is the most significant digit
  assign pos = 4'(`LCD_COLS - 1) - col;

  assign digit = sel_value[pos*4 +: 4];
  assign show  = sel_mask[pos];

  always_comb begin
    if (show) begin
      char_code = to_hex_char(digit);
    end else begin
      char_code = lcd_cmd_pkg::CHAR_SPACE;
    end
  end

endmodule

//--- lcd_seq_pkg.sv
package lcd_seq_pkg;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    // Read the busy flag until it clears
    S_POLL,
    // Instruction write, e high
    S_INSTR,
    // Data write, e high
    S_DATA,
    // End of the bus cycle, data still driven
    S_RELEASE,
    // Ready, waiting for go
    S_IDLE,
    // Pick the next step of the script
    S_NEXT
  } seq_state_e;

  // Position in the write script
  typedef enum logic [2:0] {
    INIT_FUNC,
    INIT_DISP,
    INIT_ENTRY,
    HOME,
    LINE1,
    LINE2_ADDR,
    LINE2
  } seq_step_e;

endpackage

//--- lcd_cmd_pkg.sv
package lcd_cmd_pkg;

  // HD44780 instruction opcodes used by the controller
  typedef enum logic [7:0] {
    // 8-bit bus, two lines, 5x8 font
    CMD_FUNC_SET   = 8'h38,
    // Display on, cursor on, no blink
    CMD_DISP_ON    = 8'h0e,
    // Address increments, no display shift
    CMD_ENTRY_MODE = 8'h06,
    // Cursor back to the first column of line one
    CMD_HOME       = 8'h02,
    // DDRAM address 0x40, first column of line two
    CMD_LINE2      = 8'hc0
  } lcd_cmd_e;

  // One character code as written to display RAM
  typedef logic [7:0] lcd_char_t;

  // Blank position
  localparam lcd_char_t CHAR_SPACE   = 8'h20;

  // Base of the digits 0 to 9
  localparam lcd_char_t CHAR_ZERO    = 8'h30;

  // Base of the lowercase letters a to f
  localparam lcd_char_t CHAR_A_LOWER = 8'h61;

endpackage

//--- lcd_cfg.svh
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// Display geometry for a 2x16 character module

// Characters per line
`define LCD_COLS 16

// One hex digit per column, four bits each
`define LCD_LINE_W 64

// Longest busy flag wait accepted before a poll is called stuck.
// The controller itself waits without limit
`define LCD_POLL_MAX 1024

`endif
